//--- bench/exec_props.sv
`timescale 1ns/1ns

module exec_props (
	input logic clk,
	input logic nrst,
	input logic start,	// loader level, seen through the ctrl modport
	input logic wb_valid,
	input logic [4:0] wb_rd,
	input logic running,
	input logic halted
);

	// start is sticky until reset
	start_held: assert property (@(posedge clk) disable iff (!nrst) start |=> start)
		else $error("start fell while out of reset");

	// x0 never written back
	no_wb_x0: assert property (@(posedge clk) disable iff (!nrst) wb_valid |-> wb_rd != 5'd0)
		else $error("writeback issued with rd zero");

	one_phase: assert property (@(posedge clk) disable iff (!nrst) !(running && halted))
		else $error("running and halted high together");

endmodule

bind exec_ctrl exec_props exec_props_inst (
	.clk(clk),
	.nrst(nrst),
	.start(dbg.start),
	.wb_valid(wb.valid),
	.wb_rd(wb.rd),
	.running(running),
	.halted(halted)
);

//--- bench/exec_tb.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module exec_tb;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int PROG_LEN = 48;	// below IMEM_DEPTH so pc stays unambiguous
	// two resets plus up to 4 cycles per loaded word and 3 per executed word plus margin
	localparam int LIMIT_CYCLES = 2 * RESET_CYCLES + PROG_LEN * 7 + 200;

	logic clk;
	logic nrst;
	logic dbg_valid;
	logic [`XLEN-1:0] dbg_data;
	logic dbg_go;
	logic running;
	logic halted;
	logic wb_valid;
	logic [4:0] wb_rd;
	logic [`XLEN-1:0] wb_data;
	logic [`IMEM_AW-1:0] pc;

	logic [31:0] lfsr_q;
	int value_errs;
	int other_errs;

	// reference model state
	logic [31:0] m_regs [32];
	logic [31:0] m_csr [4];	// mstatus, medeleg, mtvec, mepc
	int m_wb_count;
	logic [4:0] exp_rd [$];	// expected writebacks in program order
	logic [31:0] exp_data [$];

	exec_top exec_top_inst (
		.clk(clk),
		.nrst(nrst),
		.dbg_valid(dbg_valid),
		.dbg_data(dbg_data),
		.dbg_go(dbg_go),
		.running(running),
		.halted(halted),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.pc(pc)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [2:0] alu_funct3();
		case (2'(take_bits(2)))
			2'd0: return isa_pkg::F3_ADD;
			2'd1: return isa_pkg::F3_XOR;
			2'd2: return isa_pkg::F3_OR;
			default: return isa_pkg::F3_AND;
		endcase
	endfunction

	function automatic logic [11:0] pick_csr();
		case (3'(take_bits(3)))
			3'd0, 3'd4: return isa_pkg::CSR_MSTATUS;
			3'd1, 3'd5: return isa_pkg::CSR_MEDELEG;
			3'd2, 3'd6: return isa_pkg::CSR_MTVEC;
			3'd3: return isa_pkg::CSR_MEPC;
			default: return 12'h7c0;	// not implemented
		endcase
	endfunction

	// one instruction word built field by field
	function automatic logic [31:0] make_word();
		logic [6:0] op;
		logic [2:0] f3;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [11:0] hi;
		case (2'(take_bits(2)))
			2'd0, 2'd1: op = isa_pkg::OP_IMM;
			2'd2: op = isa_pkg::OP_SYSTEM;
			default: op = 7'(take_bits(7));	// mostly no-ops
		endcase
		if (2'(take_bits(2)) != 2'd3)
			f3 = (op == isa_pkg::OP_SYSTEM) ? isa_pkg::F3_CSRRWI : alu_funct3();
		else
			f3 = 3'(take_bits(3));
		rd = {2'b00, 3'(take_bits(3))};	// x0 to x7 so rd zero shows up often
		rs1 = {2'b00, 3'(take_bits(3))};
		hi = (op == isa_pkg::OP_SYSTEM) ? pick_csr() : 12'(take_bits(12));
		return {hi, rs1, f3, rd, op};
	endfunction

	function automatic int csr_slot(input logic [11:0] a);
		case (a)
			isa_pkg::CSR_MSTATUS: return 0;
			isa_pkg::CSR_MEDELEG: return 1;
			isa_pkg::CSR_MTVEC: return 2;
			isa_pkg::CSR_MEPC: return 3;
			default: return -1;
		endcase
	endfunction

	task automatic model_reset();
		for (int i = 0; i < 32; i++)
			m_regs[i] = '0;
		for (int i = 0; i < 4; i++)
			m_csr[i] = '0;
		m_wb_count = 0;
		exp_rd.delete();
		exp_data.delete();
	endtask

	// executes one word on the model and queues the expected writeback
	task automatic model_exec(input logic [31:0] w);
		logic [31:0] imm;
		logic [31:0] res;
		logic hit;
		int idx;
		imm = {{20{w[31]}}, w[31:20]};
		res = '0;
		hit = 1'b0;
		if (w[6:0] == isa_pkg::OP_IMM)
		begin
			hit = 1'b1;
			case (w[14:12])
				isa_pkg::F3_ADD: res = m_regs[w[19:15]] + imm;
				isa_pkg::F3_XOR: res = m_regs[w[19:15]] ^ imm;
				isa_pkg::F3_OR: res = m_regs[w[19:15]] | imm;
				isa_pkg::F3_AND: res = m_regs[w[19:15]] & imm;
				default: hit = 1'b0;
			endcase
		end
		else if (w[6:0] == isa_pkg::OP_SYSTEM && w[14:12] == isa_pkg::F3_CSRRWI)
		begin
			hit = 1'b1;
			idx = csr_slot(w[31:20]);
			if (idx >= 0)
			begin
				res = m_csr[idx];	// old value back
				m_csr[idx] = {27'd0, w[19:15]};	// zimm
			end
		end
		if (hit && w[11:7] != 5'd0)
		begin
			m_regs[w[11:7]] = res;
			m_wb_count++;
			exp_rd.push_back(w[11:7]);
			exp_data.push_back(res);
		end
	endtask

	task automatic check_value(input logic [31:0] exp, input logic [31:0] act, input string what);
		if (exp !== act)
		begin
			$display("[FAIL] %0t ns: %s, expected %h got %h", $time, what, exp, act);
			value_errs++;
		end
	endtask

	task automatic apply_reset();
		nrst = 1'b0;
		dbg_valid = 1'b0;
		dbg_data = '0;
		dbg_go = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		nrst = 1'b1;
	endtask

	// one load cycle with flags checked at the falling edge
	task automatic load_step(input logic loading);
		@(negedge clk);
		check_value(32'(loading), 32'(exec_top_inst.dbg_bus.debug_sig), "debug_sig during load");
		check_value(32'd0, 32'(exec_top_inst.dbg_bus.start), "start during load");
		check_value(32'd0, 32'(running), "running during load");
		check_value(32'd0, 32'(halted), "halted during load");
	endtask

	task automatic load_words(input int n);
		logic [31:0] w;
		logic loading;
		int gap;
		loading = 1'b0;
		for (int i = 0; i < n; i++)
		begin
			gap = int'(take_bits(2));	// 0..3 idle cycles
			repeat (gap) load_step(loading);
			w = make_word();
			model_exec(w);
			dbg_valid = 1'b1;
			dbg_data = w;
			loading = 1'b1;
			load_step(loading);
			dbg_valid = 1'b0;
		end
		dbg_go = 1'b1;
		@(negedge clk);
		dbg_go = 1'b0;
		check_value(32'd0, 32'(exec_top_inst.dbg_bus.debug_sig), "debug_sig after go");
		check_value(32'd1, 32'(exec_top_inst.dbg_bus.start), "start after go");
	endtask

	task automatic run_program(input int n);
		int cycles;
		int wb_seen;
		apply_reset();
		model_reset();
		load_words(n);
		cycles = 0;
		wb_seen = 0;
		while (!halted)
		begin
			@(negedge clk);
			cycles++;
			check_value(32'(!halted), 32'(running), "running until halt");
			if (wb_valid)
			begin
				wb_seen++;
				if (exp_rd.size() == 0)
				begin
					$display("writeback to x%0d at %0t ns with none expected", wb_rd, $time);
					other_errs++;
				end
				else
				begin
					check_value(32'(exp_rd.pop_front()), 32'(wb_rd), "writeback rd");
					check_value(exp_data.pop_front(), wb_data, "writeback data");
				end
			end
		end
		check_value(32'(3 * n + 1), 32'(cycles), "cycles from start to halt");
		check_value(32'(n), 32'(pc), "pc at halt");
		check_value(32'(m_wb_count), 32'(wb_seen), "writeback count");
	endtask

	// watchdog
	initial
	begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		lfsr_q = 32'd88002;
		value_errs = 0;
		other_errs = 0;
		nrst = 1'b0;
		dbg_valid = 1'b0;
		dbg_data = '0;
		dbg_go = 1'b0;
		run_program(PROG_LEN);	// random program
		run_program(0);	// empty program halts at once
		$display("errors: %0d value mismatches, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the exec_top testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exec_tb -f vlog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out="$(./obj_dir/Vexec_tb 2>&1)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

//--- source/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data and instruction word width
`define XLEN 32

// instruction memory size in words
`define IMEM_DEPTH 64

// word address width into instruction memory
`define IMEM_AW 6

`endif

//--- source/csr_file.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module csr_file (
	input logic clk,
	input logic nrst,
	input logic csr_en,	// swap request from EXEC
	input logic [11:0] csr_addr,
	input logic [`XLEN-1:0] csr_wdata,
	output logic [`XLEN-1:0] csr_rdata
);

	logic [`XLEN-1:0] mstatus_q;
	logic [`XLEN-1:0] medeleg_q;
	logic [`XLEN-1:0] mtvec_q;
	logic [`XLEN-1:0] mepc_q;

	// old value goes out before the write edge
	always_comb
	begin
		case (csr_addr)
			isa_pkg::CSR_MSTATUS: csr_rdata = mstatus_q;
			isa_pkg::CSR_MEDELEG: csr_rdata = medeleg_q;
			isa_pkg::CSR_MTVEC: csr_rdata = mtvec_q;
			isa_pkg::CSR_MEPC: csr_rdata = mepc_q;
			default: csr_rdata = '0;	// unknown CSR
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			mstatus_q <= '0;
			medeleg_q <= '0;
			mtvec_q <= '0;
			mepc_q <= '0;
		end
		else if (csr_en)
		begin
			case (csr_addr)
				isa_pkg::CSR_MSTATUS: mstatus_q <= csr_wdata;
				isa_pkg::CSR_MEDELEG: medeleg_q <= csr_wdata;
				isa_pkg::CSR_MTVEC: mtvec_q <= csr_wdata;
				isa_pkg::CSR_MEPC: mepc_q <= csr_wdata;
				default: ;	// write dropped
			endcase
		end
	end

endmodule

//--- source/ctrl_pkg.sv
`include "core_defines.svh"

package ctrl_pkg;

	// sequencer phases
	typedef enum logic [1:0] {
		IDLE,	// waiting for start
		FETCH,	// two cycles, address then data
		EXEC,	// decode, compute, write back
		HALT	// end of program, sticky
	} seq_state_e;

	// one register write, 38 bits
	typedef struct packed {
		logic valid;
		logic [4:0] rd;
		logic [`XLEN-1:0] data;
	} wb_s;

endpackage

//--- source/debug_if.sv
`timescale 1ns/1ns
`include "core_defines.svh"

interface debug_if;

	logic debug_sig;	// high while a program is loading
	logic debug_we;	// one pulse per word
	logic [`IMEM_AW-1:0] debug_addr;
	logic [`XLEN-1:0] debug_instr;
	logic start;	// sticky once loading ends
	logic [`IMEM_AW:0] prog_len;	// words loaded, up to IMEM_DEPTH

	modport loader (
		output debug_sig, debug_we, debug_addr, debug_instr, start, prog_len
	);

	modport mem (input debug_we, debug_addr, debug_instr);

	modport ctrl (input start, prog_len);

endinterface

//--- source/debug_loader.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module debug_loader (
	input logic clk,
	input logic nrst,
	input logic dbg_valid,	// one word per high cycle
	input logic [`XLEN-1:0] dbg_data,
	input logic dbg_go,	// end of program
	debug_if.loader dbg
);

	logic [`IMEM_AW:0] cnt_q;	// next free address and word count
	logic word_ok;

	// words after start or past the memory end are dropped
	assign word_ok = dbg_valid && !dbg.start && (cnt_q < `IMEM_DEPTH);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			cnt_q <= '0;
			dbg.debug_we <= 1'b0;
			dbg.debug_sig <= 1'b0;
			dbg.start <= 1'b0;
		end
		else
		begin
			dbg.debug_we <= word_ok;	// aligned with addr and data below
			if (word_ok)
				cnt_q <= cnt_q + 1'b1;
			if (dbg_go)
				dbg.debug_sig <= 1'b0;	// go wins over a word in the same cycle
			else if (word_ok)
				dbg.debug_sig <= 1'b1;
			if (dbg_go)
				dbg.start <= 1'b1;	// held until reset
		end
	end

	// payload, only meaningful with debug_we
	always_ff @(posedge clk)
	begin
		if (word_ok)
		begin
			dbg.debug_addr <= cnt_q[`IMEM_AW-1:0];
			dbg.debug_instr <= dbg_data;
		end
	end

	assign dbg.prog_len = cnt_q;	// frozen once start is up

endmodule

//--- source/exec_ctrl.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module exec_ctrl (
	input logic clk,
	input logic nrst,
	debug_if.ctrl dbg,
	output logic [`IMEM_AW-1:0] rd_addr,
	input isa_pkg::instr_u rd_data,
	output logic [4:0] rs1_idx,
	input logic [`XLEN-1:0] rs1_val,
	output logic csr_en,
	output logic [11:0] csr_addr,
	output logic [`XLEN-1:0] csr_wdata,
	input logic [`XLEN-1:0] csr_rdata,
	output ctrl_pkg::wb_s wb,
	output logic running,
	output logic halted,
	output logic [`IMEM_AW-1:0] pc
);

	ctrl_pkg::seq_state_e state_q;
	logic data_rdy_q;	// memory output valid in second fetch cycle
	logic [`IMEM_AW:0] pc_q;	// one extra bit so pc can reach a full memory
	logic [`IMEM_AW:0] pc_next;
	isa_pkg::instr_u instr_q;	// word under execution
	logic is_alu;
	logic is_csr;
	logic [`XLEN-1:0] imm_sext;
	logic [`XLEN-1:0] alu_res;
	logic exec;

	assign pc_next = pc_q + 1'b1;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state_q <= ctrl_pkg::IDLE;
			data_rdy_q <= 1'b0;
			pc_q <= '0;
		end
		else
		begin
			case (state_q)
				ctrl_pkg::IDLE:
					if (dbg.start)	// empty program halts at once
						state_q <= (dbg.prog_len == '0) ? ctrl_pkg::HALT : ctrl_pkg::FETCH;
				ctrl_pkg::FETCH:
				begin
					data_rdy_q <= !data_rdy_q;
					if (data_rdy_q)
						state_q <= ctrl_pkg::EXEC;
				end
				ctrl_pkg::EXEC:
				begin
					pc_q <= pc_next;
					state_q <= (pc_next == dbg.prog_len) ? ctrl_pkg::HALT : ctrl_pkg::FETCH;
				end
				ctrl_pkg::HALT: ;	// stays until reset
				default: state_q <= ctrl_pkg::IDLE;
			endcase
		end
	end

	// capture the fetched word at the end of fetch
	always_ff @(posedge clk)
	begin
		if (state_q == ctrl_pkg::FETCH && data_rdy_q)
			instr_q <= rd_data;
	end

	assign rd_addr = pc_q[`IMEM_AW-1:0];	// held for the whole fetch
	assign exec = (state_q == ctrl_pkg::EXEC);

	// decode through both views of instr_q
	always_comb
	begin
		is_alu = (instr_q.i_fmt.opcode == isa_pkg::OP_IMM) &&
			(instr_q.i_fmt.funct3 == isa_pkg::F3_ADD ||
			instr_q.i_fmt.funct3 == isa_pkg::F3_XOR ||
			instr_q.i_fmt.funct3 == isa_pkg::F3_OR ||
			instr_q.i_fmt.funct3 == isa_pkg::F3_AND);
		is_csr = (instr_q.csr_fmt.opcode == isa_pkg::OP_SYSTEM) &&
			(instr_q.csr_fmt.funct3 == isa_pkg::F3_CSRRWI);
		imm_sext = {{(`XLEN-12){instr_q.i_fmt.imm12[11]}}, instr_q.i_fmt.imm12};
		case (instr_q.i_fmt.funct3)
			isa_pkg::F3_XOR: alu_res = rs1_val ^ imm_sext;
			isa_pkg::F3_OR: alu_res = rs1_val | imm_sext;
			isa_pkg::F3_AND: alu_res = rs1_val & imm_sext;
			default: alu_res = rs1_val + imm_sext;	// add
		endcase
	end

	assign rs1_idx = instr_q.i_fmt.rs1;

	// CSR swap still happens with rd of zero
	assign csr_en = exec && is_csr;
	assign csr_addr = instr_q.csr_fmt.csr_addr;
	assign csr_wdata = {{(`XLEN-5){1'b0}}, instr_q.csr_fmt.zimm};	// zero extended

	always_comb
	begin
		wb.valid = exec && (is_alu || is_csr) && (instr_q.i_fmt.rd != 5'd0);
		wb.rd = instr_q.i_fmt.rd;
		wb.data = is_csr ? csr_rdata : alu_res;	// old CSR value on a swap
	end

	assign running = (state_q == ctrl_pkg::FETCH) || exec;
	assign halted = (state_q == ctrl_pkg::HALT);
	assign pc = pc_q[`IMEM_AW-1:0];

endmodule

//--- source/exec_top.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module exec_top (
	input logic clk,
	input logic nrst,
	input logic dbg_valid,
	input logic [`XLEN-1:0] dbg_data,
	input logic dbg_go,
	output logic running,
	output logic halted,
	output logic wb_valid,
	output logic [4:0] wb_rd,
	output logic [`XLEN-1:0] wb_data,
	output logic [`IMEM_AW-1:0] pc
);

	debug_if dbg_bus ();	// loader to memory and sequencer

	logic [`IMEM_AW-1:0] rd_addr;
	isa_pkg::instr_u rd_data;
	logic [4:0] rs1_idx;
	logic [`XLEN-1:0] rs1_val;
	logic csr_en;
	logic [11:0] csr_addr;
	logic [`XLEN-1:0] csr_wdata;
	logic [`XLEN-1:0] csr_rdata;
	ctrl_pkg::wb_s wb;

	debug_loader debug_loader_inst (
		.clk(clk),
		.nrst(nrst),
		.dbg_valid(dbg_valid),
		.dbg_data(dbg_data),
		.dbg_go(dbg_go),
		.dbg(dbg_bus.loader)
	);

	instr_mem instr_mem_inst (
		.clk(clk),
		.dbg(dbg_bus.mem),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	exec_ctrl exec_ctrl_inst (
		.clk(clk),
		.nrst(nrst),
		.dbg(dbg_bus.ctrl),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.rs1_idx(rs1_idx),
		.rs1_val(rs1_val),
		.csr_en(csr_en),
		.csr_addr(csr_addr),
		.csr_wdata(csr_wdata),
		.csr_rdata(csr_rdata),
		.wb(wb),
		.running(running),
		.halted(halted),
		.pc(pc)
	);

	reg_file reg_file_inst (
		.clk(clk),
		.nrst(nrst),
		.rs1_idx(rs1_idx),
		.rs1_val(rs1_val),
		.wb(wb)
	);

	csr_file csr_file_inst (
		.clk(clk),
		.nrst(nrst),
		.csr_en(csr_en),
		.csr_addr(csr_addr),
		.csr_wdata(csr_wdata),
		.csr_rdata(csr_rdata)
	);

	// writeback record out on plain ports
	assign wb_valid = wb.valid;
	assign wb_rd = wb.rd;
	assign wb_data = wb.data;

endmodule

//--- source/instr_mem.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module instr_mem (
	input logic clk,
	debug_if.mem dbg,
	input logic [`IMEM_AW-1:0] rd_addr,
	output isa_pkg::instr_u rd_data
);

	isa_pkg::instr_u mem [`IMEM_DEPTH];	// no reset on contents

	// load port, debug side only
	always_ff @(posedge clk)
	begin
		if (dbg.debug_we)
			mem[dbg.debug_addr] <= dbg.debug_instr;
	end

	// registered read, data one cycle after address
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- source/isa_pkg.sv
package isa_pkg;

	// I-type layout, used by OP-IMM
	typedef struct packed {
		logic [11:0] imm12;	// sign extended at decode
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_s;

	// same bits seen as a CSR immediate op
	typedef struct packed {
		logic [11:0] csr_addr;
		logic [4:0] zimm;	// rs1 slot carries the immediate
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} csr_fmt_s;

	typedef union packed {
		i_fmt_s i_fmt;
		csr_fmt_s csr_fmt;
	} instr_u;

	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [2:0] F3_CSRRWI = 3'b101;	// system group

	// machine mode CSRs that exist here
	localparam logic [11:0] CSR_MSTATUS = 12'h300;
	localparam logic [11:0] CSR_MEDELEG = 12'h302;
	localparam logic [11:0] CSR_MTVEC = 12'h305;
	localparam logic [11:0] CSR_MEPC = 12'h341;

endpackage

//--- source/reg_file.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module reg_file (
	input logic clk,
	input logic nrst,
	input logic [4:0] rs1_idx,
	output logic [`XLEN-1:0] rs1_val,
	input ctrl_pkg::wb_s wb
);

	logic [`XLEN-1:0] regs [1:31];	// x0 has no storage

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb.valid && wb.rd != 5'd0)
			regs[wb.rd] <= wb.data;
	end

	// combinational read, no bypass from wb
	assign rs1_val = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];

endmodule

//--- vlog.f
+incdir+source
source/isa_pkg.sv
source/ctrl_pkg.sv
source/debug_if.sv
source/debug_loader.sv
source/instr_mem.sv
source/exec_ctrl.sv
source/reg_file.sv
source/csr_file.sv
source/exec_top.sv
bench/exec_props.sv
bench/exec_tb.sv
